//--- button_sampler.sv
module button_sampler
    import chrono_pkg::*;
#(
    parameter int sample_period = chrono_pkg::sample_period
) (
    input  logic     clk,
    input  logic     reset,
    input  buttons_t buttons,
    output pulses_t  pulses
);

    localparam int cnt_w = (sample_period > 1) ? $clog2(sample_period) : 1;
    localparam logic [cnt_w-1:0] last_count = cnt_w'(sample_period - 1);

    logic [cnt_w-1:0] count; // shared by all four action buttons

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count  <= '0;
            pulses <= '0;
        end else if (count == last_count) begin
            count         <= '0;
            pulses.inc    <= buttons.inc;
            pulses.dec    <= buttons.dec;
            pulses.field  <= buttons.field_button;
            pulses.action <= buttons.action_button;
        end else begin
            count  <= count + 1'b1;
            pulses <= '0; // pulse lasts one cycle only
        end
    end

endmodule

//--- chrono_pkg.sv
package chrono_pkg;

    typedef struct packed {
        logic [5:0] hours;
        logic [5:0] minutes;
        logic [5:0] seconds;
        logic [6:0] hundredths;
    } time_t;

    typedef struct packed {
        logic [2:0] mode_buttons; // one-hot select for clock, timer and stopwatch
        logic       inc;
        logic       dec;
        logic       field_button;
        logic       action_button;
    } buttons_t;

    typedef struct packed {
        logic inc;
        logic dec;
        logic field;
        logic action;
    } pulses_t;

    typedef enum logic [1:0] {
        MODE_CLOCK     = 2'd1,
        MODE_TIMER     = 2'd2,
        MODE_STOPWATCH = 2'd3
    } display_mode_t;

    typedef enum logic [1:0] {
        FIELD_HOURS,
        FIELD_MINUTES,
        FIELD_RUN
    } set_field_t;

    typedef enum logic [1:0] {
        TIMER_STOPPED,
        TIMER_RUNNING,
        TIMER_EXPIRED
    } timer_state_t;

    // index 7 is hours tens down to index 0 for hundredths ones
    // bit 7 of each digit is the dp
    typedef logic [7:0][7:0] seg_digits_t;

    localparam logic [5:0] max_hours      = 6'd23;
    localparam logic [5:0] max_minutes    = 6'd59;
    localparam logic [5:0] max_seconds    = 6'd59;
    localparam logic [6:0] max_hundredths = 7'd99;

    localparam int sample_period = 25; // quarter second at 100 Hz

    // one hundredth forward with carry up to the hours
    function automatic time_t time_increment(input time_t t);
        time_t n;
        n = t;
        if (t.hundredths != max_hundredths) begin
            n.hundredths = t.hundredths + 7'd1;
        end else begin
            n.hundredths = 7'd0;
            if (t.seconds != max_seconds) begin
                n.seconds = t.seconds + 6'd1;
            end else begin
                n.seconds = 6'd0;
                if (t.minutes != max_minutes) begin
                    n.minutes = t.minutes + 6'd1;
                end else begin
                    n.minutes = 6'd0;
                    n.hours   = (t.hours == max_hours) ? 6'd0 : t.hours + 6'd1;
                end
            end
        end
        return n;
    endfunction

    // one hundredth back with borrow up to the hours
    function automatic time_t time_decrement(input time_t t);
        time_t n;
        n = t;
        if (t.hundredths != 7'd0) begin
            n.hundredths = t.hundredths - 7'd1;
        end else begin
            n.hundredths = max_hundredths;
            if (t.seconds != 6'd0) begin
                n.seconds = t.seconds - 6'd1;
            end else begin
                n.seconds = max_seconds;
                if (t.minutes != 6'd0) begin
                    n.minutes = t.minutes - 6'd1;
                end else begin
                    n.minutes = max_minutes;
                    n.hours   = (t.hours == 6'd0) ? max_hours : t.hours - 6'd1;
                end
            end
        end
        return n;
    endfunction

    // hours or minutes setting where inc wins over dec
    function automatic time_t set_time_step(input time_t t, input set_field_t field,
                                            input logic inc, input logic dec);
        time_t n;
        n = t;
        case (field)
            FIELD_HOURS: begin
                if (inc)
                    n.hours = (t.hours == max_hours) ? 6'd0 : t.hours + 6'd1;
                else if (dec)
                    n.hours = (t.hours == 6'd0) ? max_hours : t.hours - 6'd1;
            end
            FIELD_MINUTES: begin
                if (inc)
                    n.minutes = (t.minutes == max_minutes) ? 6'd0 : t.minutes + 6'd1;
                else if (dec)
                    n.minutes = (t.minutes == 6'd0) ? max_minutes : t.minutes - 6'd1;
            end
            default: n = t;
        endcase
        return n;
    endfunction

    function automatic set_field_t next_set_field(input set_field_t field);
        case (field)
            FIELD_HOURS:   return FIELD_MINUTES;
            FIELD_MINUTES: return FIELD_RUN;
            default:       return FIELD_HOURS;
        endcase
    endfunction

endpackage

//--- chrono_top.sv
module chrono_top #(
    parameter int sample_period = chrono_pkg::sample_period
) (
    input  logic                      clk,
    input  logic                      reset,
    input  chrono_pkg::buttons_t      buttons,
    output chrono_pkg::seg_digits_t   digits,
    output chrono_pkg::display_mode_t mode,
    output logic                      timer_done
);

    chrono_pkg::pulses_t pulses;
    chrono_pkg::time_t   clock_time;
    chrono_pkg::time_t   timer_time;
    chrono_pkg::time_t   watch_time;

    button_sampler #(
        .sample_period(sample_period)
    ) u_button_sampler (
        .clk    (clk),
        .reset  (reset),
        .buttons(buttons),
        .pulses (pulses)
    );

    mode_select u_mode_select (
        .clk         (clk),
        .reset       (reset),
        .mode_buttons(buttons.mode_buttons),
        .mode        (mode)
    );

    wall_clock u_wall_clock (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .pulses    (pulses),
        .clock_time(clock_time)
    );

    countdown_timer u_countdown_timer (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .pulses    (pulses),
        .timer_time(timer_time),
        .timer_done(timer_done)
    );

    stopwatch u_stopwatch (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .pulses    (pulses),
        .watch_time(watch_time)
    );

    display_driver u_display_driver (
        .mode      (mode),
        .clock_time(clock_time),
        .timer_time(timer_time),
        .watch_time(watch_time),
        .digits    (digits)
    );

endmodule

//--- countdown_timer.sv
module countdown_timer
    import chrono_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  display_mode_t mode,
    input  pulses_t       pulses,
    output time_t         timer_time,
    output logic          timer_done
);

    timer_state_t state;
    timer_state_t next_state;
    set_field_t   field;
    set_field_t   next_field;
    time_t        next_time;
    logic         next_done;
    logic         setting; // hours or minutes selected

    assign setting = (field == FIELD_HOURS) || (field == FIELD_MINUTES);

    always_comb begin
        next_state = state;
        next_field = field;
        next_time  = timer_time;
        next_done  = timer_done;

        if (mode == MODE_TIMER) begin
            case (state)
                TIMER_STOPPED: begin
                    if (pulses.field)
                        next_field = next_set_field(field);
                    if (setting && (pulses.inc || pulses.dec)) begin
                        next_time = set_time_step(timer_time, field, pulses.inc, pulses.dec);
                        next_done = 1'b0; // a new setting clears expiry
                    end
                    if (pulses.action && field == FIELD_RUN)
                        next_state = TIMER_RUNNING;
                end
                TIMER_RUNNING: begin
                    if (pulses.action && field == FIELD_RUN)
                        next_state = TIMER_STOPPED;
                    if (timer_time == '0) begin
                        next_state = TIMER_EXPIRED;
                        next_done  = 1'b1;
                    end else begin
                        next_time = time_decrement(timer_time);
                        // expire on the step that lands on zero
                        if (next_time == '0) begin
                            next_state = TIMER_EXPIRED;
                            next_done  = 1'b1;
                        end
                    end
                end
                TIMER_EXPIRED: begin
                    // acknowledge keeps the flag up until the next setting
                    if (pulses.field) begin
                        next_state = TIMER_STOPPED;
                        next_field = FIELD_HOURS;
                        next_done  = 1'b1;
                    end
                end
                default: next_state = TIMER_STOPPED;
            endcase
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state      <= TIMER_STOPPED;
            field      <= FIELD_HOURS;
            timer_time <= '0;
            timer_done <= 1'b0;
        end else begin
            state      <= next_state;
            field      <= next_field;
            timer_time <= next_time;
            timer_done <= next_done;
        end
    end

endmodule

//--- display_driver.sv
module display_driver
    import chrono_pkg::*;
(
    input  display_mode_t mode,
    input  time_t         clock_time,
    input  time_t         timer_time,
    input  time_t         watch_time,
    output seg_digits_t   digits
);

    localparam logic [7:0] dp_mask = 8'b0101_0100; // hours, minutes, seconds ones

    time_t      shown;
    logic [7:0] hours_bcd;
    logic [7:0] minutes_bcd;
    logic [7:0] seconds_bcd;
    logic [7:0] hundredths_bcd;
    logic [3:0] dec_digit [8];

    // tens in the upper nibble, ones in the lower
    function automatic logic [7:0] to_bcd(input logic [6:0] value);
        logic [6:0] rest;
        logic [3:0] tens;
        rest = value;
        tens = 4'd0;
        for (int i = 0; i < 12; i++) begin
            if (rest >= 7'd10) begin
                rest = rest - 7'd10;
                tens = tens + 4'd1;
            end
        end
        return {tens, rest[3:0]};
    endfunction

    function automatic logic [6:0] seg_encode(input logic [3:0] value);
        case (value)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h67;
            default: return 7'h00; // blank
        endcase
    endfunction

    always_comb begin
        case (mode)
            MODE_TIMER:     shown = timer_time;
            MODE_STOPWATCH: shown = watch_time;
            default:        shown = clock_time;
        endcase
        if (mode != MODE_STOPWATCH)
            shown.hundredths = 7'd0; // only the stopwatch shows hundredths
    end

    assign hours_bcd      = to_bcd({1'b0, shown.hours});
    assign minutes_bcd    = to_bcd({1'b0, shown.minutes});
    assign seconds_bcd    = to_bcd({1'b0, shown.seconds});
    assign hundredths_bcd = to_bcd(shown.hundredths);

    assign dec_digit[7] = hours_bcd[7:4];
    assign dec_digit[6] = hours_bcd[3:0];
    assign dec_digit[5] = minutes_bcd[7:4];
    assign dec_digit[4] = minutes_bcd[3:0];
    assign dec_digit[3] = seconds_bcd[7:4];
    assign dec_digit[2] = seconds_bcd[3:0];
    assign dec_digit[1] = hundredths_bcd[7:4];
    assign dec_digit[0] = hundredths_bcd[3:0];

    always_comb begin
        for (int i = 0; i < 8; i++)
            digits[i] = {dp_mask[i], seg_encode(dec_digit[i])};
    end

endmodule

//--- mode_select.sv
module mode_select
    import chrono_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [2:0]    mode_buttons,
    output display_mode_t mode
);

    display_mode_t next_mode;

    always_comb begin
        next_mode = mode;
        case (mode_buttons)
            3'b001:  next_mode = MODE_CLOCK;
            3'b010:  next_mode = MODE_TIMER;
            3'b100:  next_mode = MODE_STOPWATCH;
            default: next_mode = mode; // none or several pressed
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            mode <= MODE_CLOCK;
        else
            mode <= next_mode;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_chrono_top \
    -o tb_chrono_top

./obj_dir/tb_chrono_top | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation completed without failure"

//--- stopwatch.sv
module stopwatch
    import chrono_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  display_mode_t mode,
    input  pulses_t       pulses,
    output time_t         watch_time
);

    logic  running;
    logic  next_running;
    time_t next_time;

    always_comb begin
        next_running = running;
        // counts in the background too and wraps past 23:59:59.99
        next_time    = running ? time_increment(watch_time) : watch_time;

        if (mode == MODE_STOPWATCH) begin
            if (pulses.field)
                next_running = !running;
            if (pulses.action) begin // clear beats toggle
                next_running = 1'b0;
                next_time    = '0;
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            running    <= 1'b0;
            watch_time <= '0;
        end else begin
            running    <= next_running;
            watch_time <= next_time;
        end
    end

endmodule

//--- tb_chrono_top.sv
module tb_chrono_top
    import chrono_pkg::*;
();

    localparam int press_period = 5;
    localparam int timer_cycles = 6000;                 // one minute at 100 Hz
    localparam int cycle_limit  = timer_cycles + 14000; // rest of the tests plus margin

    localparam int btn_inc    = 0;
    localparam int btn_dec    = 1;
    localparam int btn_field  = 2;
    localparam int btn_action = 3;

    logic          clk;
    logic          reset;
    buttons_t      buttons;
    seg_digits_t   digits;
    display_mode_t mode;
    logic          timer_done;

    int          errors = 0;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    logic [31:0] lcg_state;
    int          hh, mm, ss, cc;
    int          exp_hours;
    int          exp_minutes;
    int          n_inc;
    int          value;
    int          prev_value;
    int          secs_before;
    int          waited;
    seg_digits_t held;

    chrono_top #(
        .sample_period(press_period)
    ) u_chrono_top (
        .clk       (clk),
        .reset     (reset),
        .buttons   (buttons),
        .digits    (digits),
        .mode      (mode),
        .timer_done(timer_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] dp_pattern(input seg_digits_t d);
        logic [7:0] p;
        for (int i = 0; i < 8; i++)
            p[i] = d[i][7];
        return p;
    endfunction

    assert property (@(posedge clk) disable iff (reset) dp_pattern(digits) == 8'h54)
        else begin
            errors++;
            $display("FAILED at %0t: decimal points %h, expected 54", $time, dp_pattern(digits));
        end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int seg_value(input logic [6:0] seg);
        case (seg)
            7'h3F:   return 0;
            7'h06:   return 1;
            7'h5B:   return 2;
            7'h4F:   return 3;
            7'h66:   return 4;
            7'h6D:   return 5;
            7'h7D:   return 6;
            7'h07:   return 7;
            7'h7F:   return 8;
            7'h67:   return 9;
            default: return -1;
        endcase
    endfunction

    task automatic check_equal(input int got, input int expected, input string what);
        assert (got == expected) else begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("FAILED at %0t: %s", $time, what);
        end
    endtask

    // decode at the falling edge where outputs are settled
    task automatic read_display(output int h, output int m, output int s, output int c);
        int d [8];
        @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            d[i] = seg_value(digits[i][6:0]);
            assert (d[i] >= 0) else begin
                errors++;
                $display("digit %0d shows an unknown segment pattern %h at time %0t",
                         i, digits[i][6:0], $time);
            end
        end
        h = d[7] * 10 + d[6];
        m = d[5] * 10 + d[4];
        s = d[3] * 10 + d[2];
        c = d[1] * 10 + d[0];
    endtask

    task automatic expect_zero_display(input string what);
        int h, m, s, c;
        read_display(h, m, s, c);
        check_equal(h, 0, {what, " hours"});
        check_equal(m, 0, {what, " minutes"});
        check_equal(s, 0, {what, " seconds"});
        check_equal(c, 0, {what, " hundredths"});
    endtask

    // held for one sampling period and released for one to give a single pulse
    task automatic press_button(input int which);
        buttons_t pattern;
        pattern = '0;
        case (which)
            btn_inc:   pattern.inc = 1'b1;
            btn_dec:   pattern.dec = 1'b1;
            btn_field: pattern.field_button = 1'b1;
            default:   pattern.action_button = 1'b1;
        endcase
        @(posedge clk);
        buttons <= pattern;
        repeat (press_period) @(posedge clk);
        buttons <= '0;
        repeat (press_period) @(posedge clk);
    endtask

    task automatic select_mode(input logic [2:0] one_hot);
        @(posedge clk);
        buttons.mode_buttons <= one_hot;
        repeat (2) @(posedge clk);
        buttons.mode_buttons <= 3'b000;
        @(posedge clk);
    endtask

    task automatic begin_test();
        test_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
    endtask

    initial begin
        reset     = 1'b1;
        buttons   = '0;
        lcg_state = 32'h5d53_b55f;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        begin_test();
        expect_zero_display("reset");
        check_true(mode == MODE_CLOCK, "mode is not MODE_CLOCK after reset");
        check_equal(int'(dp_pattern(digits)), 'h54, "decimal point pattern");
        check_equal(int'(timer_done), 0, "timer_done after reset");
        end_test("reset");

        begin_test();
        press_button(btn_dec);
        exp_hours = 23; // wraps below zero
        read_display(hh, mm, ss, cc);
        check_equal(hh, exp_hours, "clock hours after dec");
        n_inc = int'((next_random() >> 16) % 32'd5) + 1;
        repeat (n_inc) press_button(btn_inc);
        exp_hours = (exp_hours + n_inc) % 24;
        read_display(hh, mm, ss, cc);
        check_equal(hh, exp_hours, "clock hours after inc");
        press_button(btn_field);
        press_button(btn_dec);
        n_inc = int'((next_random() >> 16) % 32'd5) + 1;
        repeat (n_inc) press_button(btn_inc);
        exp_minutes = (59 + n_inc) % 60;
        read_display(hh, mm, ss, cc);
        check_equal(mm, exp_minutes, "clock minutes after setting");
        press_button(btn_field); // now running
        repeat (250) @(posedge clk);
        read_display(hh, mm, ss, cc);
        check_true(ss == 2 || ss == 3, "clock seconds not 2 or 3 after 250 cycles");
        check_equal(hh, exp_hours, "running clock hours");
        check_equal(mm, exp_minutes, "running clock minutes");
        check_equal(cc, 0, "hundredths shown in clock mode");
        end_test("clock setting");

        begin_test();
        select_mode(3'b010);
        check_true(mode == MODE_TIMER, "timer mode not selected");
        press_button(btn_inc);
        select_mode(3'b001);
        check_true(mode == MODE_CLOCK, "clock mode not selected");
        read_display(hh, mm, ss, cc);
        check_equal(hh, exp_hours, "clock hours after inc in timer mode");
        secs_before = ss;
        repeat (200) @(posedge clk);
        read_display(hh, mm, ss, cc);
        check_true(ss > secs_before, "clock seconds stopped advancing");
        end_test("mode isolation");

        begin_test();
        select_mode(3'b010);
        read_display(hh, mm, ss, cc);
        check_equal(hh, 1, "timer hours from the earlier inc");
        press_button(btn_dec);
        press_button(btn_field);
        press_button(btn_inc);
        press_button(btn_field);
        read_display(hh, mm, ss, cc);
        check_equal(hh * 3600 + mm * 60 + ss, 60, "timer setting in seconds");
        press_button(btn_action);
        prev_value = 60;
        waited     = 2 * press_period; // the press itself counts
        while (!timer_done && waited < timer_cycles + 100) begin
            read_display(hh, mm, ss, cc);
            value = hh * 3600 + mm * 60 + ss;
            check_true(value <= prev_value, "timer display increased while counting down");
            prev_value = value;
            waited++;
        end
        check_true(timer_done, "timer did not expire within 6100 cycles");
        expect_zero_display("expired timer");
        press_button(btn_field);
        check_equal(int'(timer_done), 1, "timer_done after acknowledge");
        press_button(btn_inc);
        read_display(hh, mm, ss, cc);
        check_equal(int'(timer_done), 0, "timer_done after new setting");
        check_equal(hh, 1, "timer hours after inc");
        end_test("timer");

        begin_test();
        select_mode(3'b100);
        check_true(mode == MODE_STOPWATCH, "stopwatch mode not selected");
        press_button(btn_field);
        repeat (150) @(posedge clk);
        read_display(hh, mm, ss, cc);
        check_true(cc != 0 || ss == 1, "stopwatch shows no elapsed time after 150 cycles");
        press_button(btn_field);
        @(negedge clk);
        held = digits;
        repeat (50) begin
            @(negedge clk);
            check_true(digits == held, "stopped stopwatch display changed");
        end
        press_button(btn_action);
        expect_zero_display("cleared stopwatch");
        end_test("stopwatch");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
chrono_pkg.sv
button_sampler.sv
mode_select.sv
wall_clock.sv
countdown_timer.sv
stopwatch.sv
display_driver.sv
chrono_top.sv
tb_chrono_top.sv

//--- wall_clock.sv
module wall_clock
    import chrono_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  display_mode_t mode,
    input  pulses_t       pulses,
    output time_t         clock_time
);

    set_field_t field;
    set_field_t next_field;
    time_t      next_time;

    always_comb begin
        next_field = field;
        next_time  = clock_time;

        // setting only while the clock is on display
        if (mode == MODE_CLOCK) begin
            if (pulses.field)
                next_field = next_set_field(field);
            next_time = set_time_step(clock_time, field, pulses.inc, pulses.dec);
        end

        // keeps time in any mode
        if (field == FIELD_RUN)
            next_time = time_increment(clock_time);
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            field      <= FIELD_HOURS;
            clock_time <= '0;
        end else begin
            field      <= next_field;
            clock_time <= next_time;
        end
    end

endmodule
